// File: Makefile
# Verilator build and run for the context store testbench.

VERILATOR ?= verilator
TOP       ?= context_store_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi; \
	if [ $$status -ne 0 ] || ! grep -q "TB PASSED" $(LOG); then \
		echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
source/ctx_pkg.sv
source/cmd_dispatch.sv
source/hart_state.sv
source/resp_collect.sv
source/context_store_top.sv
verification/context_store_sva.sv
verification/context_store_tb.sv

// File: source/cmd_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_dispatch (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            cmd_valid,
    input  wire logic                            cmd_ready,
    input  ctx_pkg::hart_id_t                    cmd_hart,
    input  ctx_pkg::cmd_op_t                     cmd_op,
    input  ctx_pkg::reg_addr_t                   cmd_addr1,
    input  ctx_pkg::csr_addr_t                   cmd_csr,
    input  ctx_pkg::xlen_t                       cmd_wdata,
    output logic [ctx_pkg::num_harts-1:0]        gpr_we,
    output logic [ctx_pkg::num_harts-1:0]        csr_we,
    output ctx_pkg::reg_addr_t                   waddr,
    output ctx_pkg::csr_addr_t                   csr_addr,
    output ctx_pkg::xlen_t                       wdata,
    output logic                                 accept,
    output logic                                 legal,
    output ctx_pkg::hart_id_t                    sel_hart,
    output ctx_pkg::cmd_op_t                     sel_op
);

    import ctx_pkg::*;

    logic        hart_ok;
    logic        is_csr_op;
    logic        do_write;
    logic        do_swap;
    logic [31:0] accept_count;

    assign accept = cmd_valid && cmd_ready;

    // an out-of-range hart or an unknown CSR on a CSR op makes the command illegal.
    assign hart_ok   = (int'(cmd_hart) < num_harts);
    assign is_csr_op = (cmd_op == op_read_csr) || (cmd_op == op_swap_csr);
    assign legal     = hart_ok && (!is_csr_op || csr_known(cmd_csr));

    assign do_write = accept && legal && (cmd_op == op_write_gpr);
    assign do_swap  = accept && legal && (cmd_op == op_swap_csr);

    // only the addressed hart sees an enable, so the enables are one-hot or zero.
    always_comb begin
        for (int h = 0; h < num_harts; h++) begin
            gpr_we[h] = do_write && (cmd_hart == hart_id_t'(h));
            csr_we[h] = do_swap && (cmd_hart == hart_id_t'(h));
        end
    end

    assign waddr    = cmd_addr1;
    assign csr_addr = cmd_csr;
    assign wdata    = cmd_wdata;
    assign sel_hart = cmd_hart;
    assign sel_op   = cmd_op;

    // running count of accepted commands.
    always_ff @(posedge clk) begin
        if (rst) begin
            accept_count <= '0;
        end else if (accept) begin
            accept_count <= accept_count + 32'd1;
        end
    end

endmodule

`default_nettype wire

// File: source/context_store_top.sv
`timescale 1ns/1ps
`default_nettype none

module context_store_top (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          cmd_valid,
    output logic               cmd_ready,
    input  ctx_pkg::hart_id_t  cmd_hart,
    input  ctx_pkg::cmd_op_t   cmd_op,
    input  ctx_pkg::reg_addr_t cmd_addr1,
    input  ctx_pkg::reg_addr_t cmd_addr2,
    input  ctx_pkg::csr_addr_t cmd_csr,
    input  ctx_pkg::xlen_t     cmd_wdata,
    output logic               resp_valid,
    output ctx_pkg::xlen_t     resp_data1,
    output ctx_pkg::xlen_t     resp_data2,
    output logic               resp_err,
    input  wire logic          resp_ready
);

    import ctx_pkg::*;

    logic [num_harts-1:0] gpr_we;
    logic [num_harts-1:0] csr_we;
    reg_addr_t            waddr;
    csr_addr_t            csr_addr;
    xlen_t                wdata;
    logic                 accept;
    logic                 legal;
    hart_id_t             sel_hart;
    cmd_op_t              sel_op;
    xlen_t                rdata1    [num_harts];
    xlen_t                rdata2    [num_harts];
    xlen_t                csr_rdata [num_harts];

    cmd_dispatch u_dispatch (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_hart  (cmd_hart),
        .cmd_op    (cmd_op),
        .cmd_addr1 (cmd_addr1),
        .cmd_csr   (cmd_csr),
        .cmd_wdata (cmd_wdata),
        .gpr_we    (gpr_we),
        .csr_we    (csr_we),
        .waddr     (waddr),
        .csr_addr  (csr_addr),
        .wdata     (wdata),
        .accept    (accept),
        .legal     (legal),
        .sel_hart  (sel_hart),
        .sel_op    (sel_op)
    );

    // all harts share the read addresses; the collector picks one result.
    for (genvar h = 0; h < num_harts; h++) begin : gen_hart
        hart_state u_hart (
            .clk       (clk),
            .rst       (rst),
            .gpr_we    (gpr_we[h]),
            .csr_we    (csr_we[h]),
            .waddr     (waddr),
            .wdata     (wdata),
            .raddr1    (cmd_addr1),
            .raddr2    (cmd_addr2),
            .csr_addr  (csr_addr),
            .rdata1    (rdata1[h]),
            .rdata2    (rdata2[h]),
            .csr_rdata (csr_rdata[h])
        );
    end

    resp_collect u_collect (
        .clk        (clk),
        .rst        (rst),
        .accept     (accept),
        .legal      (legal),
        .sel_hart   (sel_hart),
        .sel_op     (sel_op),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .csr_rdata  (csr_rdata),
        .cmd_ready  (cmd_ready),
        .resp_valid (resp_valid),
        .resp_data1 (resp_data1),
        .resp_data2 (resp_data2),
        .resp_err   (resp_err),
        .resp_ready (resp_ready)
    );

endmodule

`default_nettype wire

// File: source/ctx_pkg.sv
`default_nettype none

package ctx_pkg;

    // number of hart contexts held by the store.
    // the 2-bit hart id can name four harts, so id 3 is illegal.
    localparam int num_harts = 3;

    // number of general registers per hart.
    localparam int num_gprs = 32;

    typedef logic [1:0]  hart_id_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] xlen_t;
    typedef logic [11:0] csr_addr_t;

    // machine CSR addresses from the privileged spec.
    localparam csr_addr_t csr_mstatus = 12'h300;
    localparam csr_addr_t csr_mtvec   = 12'h305;
    localparam csr_addr_t csr_mepc    = 12'h341;
    localparam csr_addr_t csr_mcause  = 12'h342;

    // mstatus comes out of reset with MPP set to machine mode.
    localparam xlen_t mstatus_reset = 32'h0000_1800;

    // command opcodes on the command port.
    // op_swap_csr writes the new value and returns the old one, like csrrw.
    typedef enum logic [1:0] {
        op_read_gpr  = 2'd0,
        op_write_gpr = 2'd1,
        op_read_csr  = 2'd2,
        op_swap_csr  = 2'd3
    } cmd_op_t;

    // true for the four machine CSRs that a hart implements.
    function automatic logic csr_known(input csr_addr_t addr);
        logic known;
        known = (addr == csr_mstatus) || (addr == csr_mtvec) ||
                (addr == csr_mepc)    || (addr == csr_mcause);
        return known;
    endfunction

endpackage

`default_nettype wire

// File: source/hart_state.sv
`timescale 1ns/1ps
`default_nettype none

module hart_state (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          gpr_we,
    input  wire logic          csr_we,
    input  ctx_pkg::reg_addr_t waddr,
    input  ctx_pkg::xlen_t     wdata,
    input  ctx_pkg::reg_addr_t raddr1,
    input  ctx_pkg::reg_addr_t raddr2,
    input  ctx_pkg::csr_addr_t csr_addr,
    output ctx_pkg::xlen_t     rdata1,
    output ctx_pkg::xlen_t     rdata2,
    output ctx_pkg::xlen_t     csr_rdata
);

    import ctx_pkg::*;

    // general registers. entry 0 is never written.
    xlen_t gprs [num_gprs];

    // machine CSRs.
    xlen_t mstatus;
    xlen_t mtvec;
    xlen_t mepc;
    xlen_t mcause;

    always_ff @(posedge clk) begin
        if (gpr_we && (waddr != '0)) begin
            gprs[waddr] <= wdata;
        end
    end

    // x0 is hard-wired to zero on both read ports.
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else begin
            rdata1 = gprs[raddr1];
        end
    end

    always_comb begin
        if (raddr2 == '0) begin
            rdata2 = '0;
        end else begin
            rdata2 = gprs[raddr2];
        end
    end

    // the read side shows the value before the edge,
    // which is what a swap returns.
    always_comb begin
        case (csr_addr)
            csr_mstatus: csr_rdata = mstatus;
            csr_mtvec:   csr_rdata = mtvec;
            csr_mepc:    csr_rdata = mepc;
            csr_mcause:  csr_rdata = mcause;
            default:     csr_rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= mstatus_reset;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (csr_we) begin
            case (csr_addr)
                csr_mstatus: begin
                    mstatus <= wdata;
                end
                csr_mtvec: begin
                    mtvec <= wdata;
                end
                csr_mepc: begin
                    mepc <= wdata;
                end
                csr_mcause: begin
                    mcause <= wdata;
                end
                default: begin
                    // unknown addresses never get an enable from the dispatcher.
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/resp_collect.sv
`timescale 1ns/1ps
`default_nettype none

module resp_collect (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        accept,
    input  wire logic        legal,
    input  ctx_pkg::hart_id_t sel_hart,
    input  ctx_pkg::cmd_op_t  sel_op,
    input  ctx_pkg::xlen_t    rdata1    [ctx_pkg::num_harts],
    input  ctx_pkg::xlen_t    rdata2    [ctx_pkg::num_harts],
    input  ctx_pkg::xlen_t    csr_rdata [ctx_pkg::num_harts],
    output logic              cmd_ready,
    output logic              resp_valid,
    output ctx_pkg::xlen_t    resp_data1,
    output ctx_pkg::xlen_t    resp_data2,
    output logic              resp_err,
    input  wire logic         resp_ready
);

    import ctx_pkg::*;

    xlen_t      hart_d1;
    xlen_t      hart_d2;
    xlen_t      hart_csr;
    xlen_t      push_d1;
    xlen_t      push_d2;
    logic       push;
    logic       pop;
    xlen_t      fifo_d1  [2];
    xlen_t      fifo_d2  [2];
    logic       fifo_err [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;

    // pick the addressed hart. an illegal id matches none and reads zero.
    always_comb begin
        hart_d1  = '0;
        hart_d2  = '0;
        hart_csr = '0;
        for (int h = 0; h < num_harts; h++) begin
            if (sel_hart == hart_id_t'(h)) begin
                hart_d1  = rdata1[h];
                hart_d2  = rdata2[h];
                hart_csr = csr_rdata[h];
            end
        end
    end

    always_comb begin
        push_d1 = '0;
        push_d2 = '0;
        if (legal) begin
            case (sel_op)
                op_read_gpr: begin
                    push_d1 = hart_d1;
                    push_d2 = hart_d2;
                end
                op_read_csr, op_swap_csr: begin
                    push_d1 = hart_csr;
                end
                default: begin
                    // a GPR write answers with zero data.
                end
            endcase
        end
    end

    assign push = accept;
    assign pop  = resp_valid && resp_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_d1[wr_ptr]  <= push_d1;
            fifo_d2[wr_ptr]  <= push_d2;
            fifo_err[wr_ptr] <= !legal;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    assign cmd_ready  = (count != 2'd2);
    assign resp_valid = (count != 2'd0);
    assign resp_data1 = fifo_d1[rd_ptr];
    assign resp_data2 = fifo_d2[rd_ptr];
    assign resp_err   = fifo_err[rd_ptr];

endmodule

`default_nettype wire

// File: verification/context_store_sva.sv
`timescale 1ns/1ps
`default_nettype none

module context_store_sva (
    input wire logic        clk,
    input wire logic        rst,
    input wire logic        cmd_ready,
    input wire logic        resp_valid,
    input wire logic        resp_ready,
    input ctx_pkg::xlen_t   resp_data1,
    input ctx_pkg::xlen_t   resp_data2,
    input wire logic        resp_err,
    input wire logic [31:0] accept_count
);

    logic [31:0] resp_count;

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_count <= '0;
        end else if (resp_valid && resp_ready) begin
            resp_count <= resp_count + 32'd1;
        end
    end

    a_reset_idle: assert property (@(posedge clk) rst |=> (!resp_valid && cmd_ready))
        else $error("response port not idle after reset");

    // a stalled response keeps its payload until it is taken.
    a_stall_stable: assert property (@(posedge clk) disable iff (rst)
        (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp_data1) &&
            $stable(resp_data2) && $stable(resp_err)))
        else $error("response changed while stalled");

    a_in_flight: assert property (@(posedge clk) disable iff (rst)
        (accept_count - resp_count) <= 32'd2)
        else $error("more than two responses in flight");

endmodule

`default_nettype wire

// File: verification/context_store_tb.sv
`timescale 1ns/1ps
`default_nettype none

module context_store_tb;

    import ctx_pkg::*;

    logic      clk;
    logic      rst;
    logic      cmd_valid;
    logic      cmd_ready;
    hart_id_t  cmd_hart;
    cmd_op_t   cmd_op;
    reg_addr_t cmd_addr1;
    reg_addr_t cmd_addr2;
    csr_addr_t cmd_csr;
    xlen_t     cmd_wdata;
    logic      resp_valid;
    xlen_t     resp_data1;
    xlen_t     resp_data2;
    logic      resp_err;
    logic      resp_ready;

    integer    seed = 25309;
    int        errors = 0;
    int        checked = 0;
    logic      ready_random = 1'b0;
    csr_addr_t csr_list [5];
    xlen_t     model_gpr [num_harts][32];
    xlen_t     model_csr [num_harts][4];
    xlen_t     exp_d1 [$];
    xlen_t     exp_d2 [$];
    logic      exp_err [$];

    context_store_top UUT (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_hart   (cmd_hart),
        .cmd_op     (cmd_op),
        .cmd_addr1  (cmd_addr1),
        .cmd_addr2  (cmd_addr2),
        .cmd_csr    (cmd_csr),
        .cmd_wdata  (cmd_wdata),
        .resp_valid (resp_valid),
        .resp_data1 (resp_data1),
        .resp_data2 (resp_data2),
        .resp_err   (resp_err),
        .resp_ready (resp_ready)
    );

    bind context_store_top context_store_sva u_sva (
        .clk          (clk),
        .rst          (rst),
        .cmd_ready    (cmd_ready),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp_data1   (resp_data1),
        .resp_data2   (resp_data2),
        .resp_err     (resp_err),
        .accept_count (u_dispatch.accept_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // model slot of a machine CSR, or -1 when the hart does not implement it.
    function automatic int csr_index(input csr_addr_t addr);
        int idx;
        case (addr)
            csr_mstatus: idx = 0;
            csr_mtvec:   idx = 1;
            csr_mepc:    idx = 2;
            csr_mcause:  idx = 3;
            default:     idx = -1;
        endcase
        return idx;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("errors: %0d, responses checked: %0d", errors + 1, checked);
        $display("TB FAILED");
        $finish;
    endtask

    // updates the model, queues the expected response and waits for the accept.
    task automatic issue(input hart_id_t hart, input cmd_op_t op, input reg_addr_t a1,
                         input reg_addr_t a2, input csr_addr_t csr, input xlen_t wd);
        int    h;
        int    ci;
        int    waited;
        logic  ok;
        logic  accepted;
        xlen_t d1;
        xlen_t d2;
        h  = int'(hart);
        ci = csr_index(csr);
        ok = (h < num_harts) && (!(op == op_read_csr || op == op_swap_csr) || ci >= 0);
        d1 = '0;
        d2 = '0;
        if (ok) begin
            case (op)
                op_read_gpr: begin
                    d1 = model_gpr[h][a1];
                    d2 = model_gpr[h][a2];
                end
                op_write_gpr: begin
                    if (a1 != 5'd0) begin
                        model_gpr[h][a1] = wd;
                    end
                end
                op_read_csr: begin
                    d1 = model_csr[h][ci];
                end
                op_swap_csr: begin
                    d1 = model_csr[h][ci];
                    model_csr[h][ci] = wd;
                end
            endcase
        end
        exp_d1.push_back(d1);
        exp_d2.push_back(d2);
        exp_err.push_back(!ok);
        cmd_valid = 1'b1;
        cmd_hart  = hart;
        cmd_op    = op;
        cmd_addr1 = a1;
        cmd_addr2 = a2;
        cmd_csr   = csr;
        cmd_wdata = wd;
        accepted  = 1'b0;
        waited    = 0;
        while (!accepted) begin
            @(negedge clk);
            accepted = cmd_ready;
            @(posedge clk);
            #1;
            waited++;
            if (!accepted && waited > 64) begin
                abort_run("command port stayed busy for 64 cycles");
            end
        end
    endtask

    task automatic check_resp();
        xlen_t e1;
        xlen_t e2;
        logic  ee;
        if (exp_d1.size() == 0) begin
            $display("response arrived with no command outstanding");
            errors++;
        end else begin
            e1 = exp_d1.pop_front();
            e2 = exp_d2.pop_front();
            ee = exp_err.pop_front();
            assert (resp_data1 == e1) else begin
                $display("FAILED resp_data1: got %h, expected %h", resp_data1, e1);
                errors++;
            end
            assert (resp_data2 == e2) else begin
                $display("FAILED resp_data2: got %h, expected %h", resp_data2, e2);
                errors++;
            end
            assert (resp_err == ee) else begin
                $display("FAILED resp_err: got %h, expected %h", resp_err, ee);
                errors++;
            end
            checked++;
        end
    endtask

    // response side. ready changes after the edge and is sampled mid-cycle.
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (ready_random) begin
                resp_ready = ($random(seed) % 4) != 0;
            end else begin
                resp_ready = 1'b1;
            end
            @(negedge clk);
            if (!rst && resp_valid && resp_ready) begin
                check_resp();
            end
        end
    end

    initial begin
        int          h;
        int          c;
        int          n;
        logic [31:0] pick;
        rst        = 1'b1;
        cmd_valid  = 1'b0;
        cmd_hart   = '0;
        cmd_op     = op_read_gpr;
        cmd_addr1  = '0;
        cmd_addr2  = '0;
        cmd_csr    = '0;
        cmd_wdata  = '0;
        resp_ready = 1'b1;
        csr_list   = '{csr_mstatus, csr_mtvec, csr_mepc, csr_mcause, 12'h344};
        for (h = 0; h < num_harts; h++) begin
            for (n = 0; n < 32; n++) begin
                model_gpr[h][n] = '0;
            end
            model_csr[h] = '{32'h0000_1800, 32'h0, 32'h0, 32'h0};
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // two-port reads of fresh writes; x0 ignores its write.
        issue(2'd0, op_write_gpr, 5'd1, 5'd0, 12'h0, 32'hcafe_0001);
        issue(2'd0, op_write_gpr, 5'd2, 5'd0, 12'h0, 32'hcafe_0002);
        issue(2'd0, op_write_gpr, 5'd0, 5'd0, 12'h0, 32'hdead_beef);
        issue(2'd0, op_write_gpr, 5'd6, 5'd0, 12'h0, 32'h0000_0066);
        issue(2'd0, op_read_gpr, 5'd1, 5'd2, 12'h0, 32'h0);
        issue(2'd0, op_read_gpr, 5'd0, 5'd1, 12'h0, 32'h0);
        for (h = 0; h < num_harts; h++) begin
            issue(hart_id_t'(h), op_write_gpr, 5'd5, 5'd0, 12'h0, 32'h5000_0000 + xlen_t'(h));
        end
        for (h = 0; h < num_harts; h++) begin
            issue(hart_id_t'(h), op_read_gpr, 5'd5, 5'd0, 12'h0, 32'h0);
        end
        for (h = 0; h < num_harts; h++) begin
            for (c = 0; c < 4; c++) begin
                issue(hart_id_t'(h), op_read_csr, 5'd0, 5'd0, csr_list[c], 32'h0);
            end
        end
        for (c = 0; c < 4; c++) begin
            issue(2'd1, op_swap_csr, 5'd0, 5'd0, csr_list[c], 32'ha000_0000 + xlen_t'(c));
            issue(2'd1, op_read_csr, 5'd0, 5'd0, csr_list[c], 32'h0);
        end

        // illegal commands, then reads that show nothing changed.
        issue(2'd3, op_write_gpr, 5'd6, 5'd0, 12'h0, 32'hbad0_0006);
        issue(2'd3, op_read_gpr, 5'd6, 5'd1, 12'h0, 32'h0);
        issue(2'd3, op_swap_csr, 5'd0, 5'd0, csr_mtvec, 32'hbad0_0305);
        issue(2'd0, op_swap_csr, 5'd0, 5'd0, 12'h301, 32'hbad0_0301);
        issue(2'd0, op_read_csr, 5'd0, 5'd0, 12'h301, 32'h0);
        issue(2'd0, op_read_gpr, 5'd6, 5'd6, 12'h0, 32'h0);
        issue(2'd0, op_read_csr, 5'd0, 5'd0, csr_mtvec, 32'h0);

        // every GPR gets a value before the random mix reads it.
        ready_random = 1'b1;
        for (h = 0; h < num_harts; h++) begin
            for (n = 1; n < 32; n++) begin
                issue(hart_id_t'(h), op_write_gpr, reg_addr_t'(n), 5'd0, 12'h0, $random(seed));
            end
        end
        for (n = 0; n < 300; n++) begin
            pick = $random(seed);
            if (pick[22:20] == 3'd0) begin
                cmd_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            issue(pick[1:0], cmd_op_t'(pick[3:2]), pick[8:4], pick[13:9],
                  csr_list[pick[16:14] % 3'd5], $random(seed));
        end
        cmd_valid = 1'b0;

        n = 0;
        while (exp_d1.size() != 0) begin
            @(posedge clk);
            n++;
            if (n > 200) begin
                abort_run("responses still missing 200 cycles after the last command");
            end
        end
        @(posedge clk);
        @(negedge clk);
        assert (!resp_valid) else begin
            $display("response port still valid after every response was consumed");
            errors++;
        end
        $display("errors: %0d, responses checked: %0d", errors, checked);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
